// ==== tb.f ====
+incdir+logic
logic/demosaic_pkg.sv
logic/bayer_window.sv
logic/neighbor_sums.sv
logic/rgb_serializer.sv
logic/demosaic_top.sv
verification/demosaic_asserts.sv
verification/demosaic_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the demosaic testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module demosaic_tb
./obj_dir/Vdemosaic_tb 2>&1 | tee sim.log

if grep -q '>>> FAIL' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== verification/demosaic_tb.sv ====
`timescale 1ns/1ns
`include "demosaic_consts.svh"

module demosaic_tb;

    import demosaic_pkg::*;

    localparam int n_strips        = 2;
    localparam int n_cols          = 6;
    localparam int n_samples       = n_strips * n_cols * `DM_COL_H;
    localparam int max_gap         = 4;
    localparam int reset_cycles    = 16;
    localparam int watchdog_cycles = reset_cycles + n_samples * (3 + max_gap) + 200;

    logic        clk;
    logic        rst_n;
    logic        valid;
    pixel_t      data_in;
    logic        end_col;
    logic        end_pic;
    logic        rgb_valid;
    pixel_t      rgb_data;
    color_e      color;
    logic        col_last;
    logic        pic_last;

    logic [15:0] lfsr;
    logic [7:0]  pix [0:n_cols-1][0:`DM_COL_H-1];  // current strip, [column][row]
    logic [11:0] exp_q [$];                        // {pic, col, tag, data}
    logic [11:0] exp_word;
    int          words_seen;

    demosaic_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (valid),
        .data_in  (data_in),
        .end_col  (end_col),
        .end_pic  (end_pic),
        .rgb_valid(rgb_valid),
        .rgb_data (rgb_data),
        .color    (color),
        .col_last (col_last),
        .pic_last (pic_last)
    );

    bind rgb_serializer demosaic_asserts u_asserts (
        .clk      (clk),
        .rst_n    (rst_n),
        .rgb_valid(rgb_valid),
        .color    (color),
        .col_last (col_last),
        .pic_last (pic_last)
    );

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // bilinear RGGB interpolation around pix[cx][ry], returns {r, g, b}
    function automatic logic [23:0] ref_triplet(input int cx, input int ry);
        int c;
        int diag;
        int cross_avg;
        int h;
        int v;
        int r_exp;
        int g_exp;
        int b_exp;
        c         = int'(pix[cx][ry]);
        h         = (int'(pix[cx-1][ry]) + int'(pix[cx+1][ry])) / 2;
        v         = (int'(pix[cx][ry-1]) + int'(pix[cx][ry+1])) / 2;
        cross_avg = (int'(pix[cx-1][ry]) + int'(pix[cx+1][ry])
                     + int'(pix[cx][ry-1]) + int'(pix[cx][ry+1])) / 4;
        diag      = (int'(pix[cx-1][ry-1]) + int'(pix[cx+1][ry-1])
                     + int'(pix[cx-1][ry+1]) + int'(pix[cx+1][ry+1])) / 4;
        if (ry % 2 == 0 && cx % 2 == 0) begin         // R site
            r_exp = c;
            g_exp = cross_avg;
            b_exp = diag;
        end else if (ry % 2 == 0) begin               // G in an R row
            r_exp = h;
            g_exp = c;
            b_exp = v;
        end else if (cx % 2 == 0) begin               // G in a B row
            r_exp = v;
            g_exp = c;
            b_exp = h;
        end else begin                                // B site
            r_exp = diag;
            g_exp = cross_avg;
            b_exp = c;
        end
        return {8'(r_exp), 8'(g_exp), 8'(b_exp)};
    endfunction

    task automatic push_word(input logic [7:0] d, input color_e tag, input logic cl,
                             input logic pl);
        exp_q.push_back({pl, cl, tag, d});
    endtask

    task automatic send_sample(input int strip, input int cx, input int ry);
        logic [7:0]  sample;
        logic [7:0]  gap;
        logic [23:0] rgb;
        logic        last_col;
        logic        last_pic;
        take_bits(8, sample);
        pix[cx][ry] = sample;
        last_col = (cx == n_cols - 1) && (ry == `DM_COL_H - 1);
        last_pic = last_col && (strip == n_strips - 1);
        @(negedge clk);
        valid   = 1'b1;
        data_in = sample;
        end_col = last_col;
        end_pic = last_pic;
        if (cx >= 2 && ry >= 2) begin  // completes window one row up, one column left
            rgb = ref_triplet(cx - 1, ry - 1);
            push_word(rgb[23:16], color_r, last_col, last_pic);
            push_word(rgb[15:8], color_g, last_col, last_pic);
            push_word(rgb[7:0], color_b, last_col, last_pic);
        end
        @(negedge clk);
        valid   = 1'b0;
        end_col = 1'b0;
        end_pic = 1'b0;
        @(negedge clk);
        take_bits(2, gap);
        if (gap == 8'd3) begin  // occasional longer pause
            take_bits(2, gap);
            repeat (int'(gap) + 1) @(negedge clk);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        valid      = 1'b0;
        data_in    = '0;
        end_col    = 1'b0;
        end_pic    = 1'b0;
        lfsr       = 16'd83;
        words_seen = 0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int s = 0; s < n_strips; s++) begin
            for (int x = 0; x < n_cols; x++) begin
                for (int y = 0; y < `DM_COL_H; y++) begin
                    send_sample(s, x, y);
                end
            end
        end
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);  // catch any stray words
        $display(">>> PASS");
        $finish;
    end

    always @(posedge clk) begin
        if (rgb_valid) begin
            assert (exp_q.size() != 0)
                else stop_with_error($sformatf("Fail at %0t ns: unexpected word %0h",
                                               $time, rgb_data));
            exp_word   = exp_q.pop_front();
            words_seen = words_seen + 1;
            assert (rgb_data == exp_word[7:0])
                else stop_with_error($sformatf("Fail at %0t ns: word %0d data %0h, expected %0h",
                                               $time, words_seen, rgb_data, exp_word[7:0]));
            assert (color == color_e'(exp_word[9:8]))
                else stop_with_error($sformatf("Fail at %0t ns: word %0d tag %0d, expected %0d",
                                               $time, words_seen, color, exp_word[9:8]));
            assert (col_last == exp_word[10])
                else stop_with_error($sformatf("Fail at %0t ns: word %0d col_last %0b",
                                               $time, words_seen, col_last));
            assert (pic_last == exp_word[11])
                else stop_with_error($sformatf("Fail at %0t ns: word %0d pic_last %0b",
                                               $time, words_seen, pic_last));
        end else begin
            assert (!col_last && !pic_last)
                else stop_with_error($sformatf("Fail at %0t ns: markers set while idle",
                                               $time));
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_with_error($sformatf("timeout: output stalled with %0d words still expected",
                                  exp_q.size()));
    end

endmodule

// ==== verification/demosaic_asserts.sv ====
`timescale 1ns/1ns

module demosaic_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 rgb_valid,
    input demosaic_pkg::color_e color,
    input logic                 col_last,
    input logic                 pic_last
);

    import demosaic_pkg::*;

    r_then_g: assert property (@(posedge clk) disable iff (!rst_n)
        rgb_valid && color == color_r |=> rgb_valid && color == color_g)
        else $error("G word did not follow R");

    g_then_b: assert property (@(posedge clk) disable iff (!rst_n)
        rgb_valid && color == color_g |=> rgb_valid && color == color_b)
        else $error("B word did not follow G");

    // after B either idle or the next R
    b_then_next: assert property (@(posedge clk) disable iff (!rst_n)
        rgb_valid && color == color_b |=> !rgb_valid || color == color_r)
        else $error("bad word after B");

    markers_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rgb_valid && color != color_b |=> $stable(col_last) && $stable(pic_last))
        else $error("markers changed inside a triplet");

    idle_clean: assert property (@(posedge clk) disable iff (!rst_n)
        !rgb_valid |-> color == color_r && !col_last && !pic_last)
        else $error("idle output not cleared");

endmodule

// ==== logic/demosaic_top.sv ====
`timescale 1ns/1ns

module demosaic_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid,
    input  demosaic_pkg::pixel_t data_in,
    input  logic                 end_col,
    input  logic                 end_pic,
    output logic                 rgb_valid,
    output demosaic_pkg::pixel_t rgb_data,
    output demosaic_pkg::color_e color,
    output logic                 col_last,
    output logic                 pic_last
);

    import demosaic_pkg::*;

    pixel_t       p1;
    pixel_t       p2;
    pixel_t       p3;
    pixel_t       p4;
    pixel_t       p5;
    pixel_t       p6;
    pixel_t       p7;
    pixel_t       p8;
    pixel_t       p9;
    center_kind_e kind;
    center_kind_e kind_q;
    logic         tap_valid;
    logic         end_col_q;
    logic         end_pic_q;
    sum_t         diag_sum;
    sum_t         cross_h;
    sum_t         cross_v;
    pixel_t       center;
    logic         col_mark;
    logic         pic_mark;
    logic         sum_valid;
    logic         accept;

    bayer_window u_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (valid),
        .data_in  (data_in),
        .end_col  (end_col),
        .end_pic  (end_pic),
        .p1       (p1),
        .p2       (p2),
        .p3       (p3),
        .p4       (p4),
        .p5       (p5),
        .p6       (p6),
        .p7       (p7),
        .p8       (p8),
        .p9       (p9),
        .kind     (kind),
        .tap_valid(tap_valid),
        .end_col_q(end_col_q),
        .end_pic_q(end_pic_q)
    );

    neighbor_sums u_sums (
        .clk      (clk),
        .rst_n    (rst_n),
        .p1       (p1),
        .p2       (p2),
        .p3       (p3),
        .p4       (p4),
        .p5       (p5),
        .p6       (p6),
        .p7       (p7),
        .p8       (p8),
        .p9       (p9),
        .kind     (kind),
        .tap_valid(tap_valid),
        .end_col_q(end_col_q),
        .end_pic_q(end_pic_q),
        .accept   (accept),
        .diag_sum (diag_sum),
        .cross_h  (cross_h),
        .cross_v  (cross_v),
        .center   (center),
        .kind_q   (kind_q),
        .col_mark (col_mark),
        .pic_mark (pic_mark),
        .sum_valid(sum_valid)
    );

    rgb_serializer u_serializer (
        .clk      (clk),
        .rst_n    (rst_n),
        .diag_sum (diag_sum),
        .cross_h  (cross_h),
        .cross_v  (cross_v),
        .center   (center),
        .kind_q   (kind_q),
        .col_mark (col_mark),
        .pic_mark (pic_mark),
        .sum_valid(sum_valid),
        .accept   (accept),
        .rgb_valid(rgb_valid),
        .rgb_data (rgb_data),
        .color    (color),
        .col_last (col_last),
        .pic_last (pic_last)
    );

endmodule

// ==== logic/rgb_serializer.sv ====
`timescale 1ns/1ns

module rgb_serializer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  demosaic_pkg::sum_t         diag_sum,
    input  demosaic_pkg::sum_t         cross_h,
    input  demosaic_pkg::sum_t         cross_v,
    input  demosaic_pkg::pixel_t       center,
    input  demosaic_pkg::center_kind_e kind_q,
    input  logic                       col_mark,
    input  logic                       pic_mark,
    input  logic                       sum_valid,
    output logic                       accept,
    output logic                       rgb_valid,
    output demosaic_pkg::pixel_t       rgb_data,
    output demosaic_pkg::color_e       color,
    output logic                       col_last,
    output logic                       pic_last
);

    import demosaic_pkg::*;

    sum_t   cross_sum;
    pixel_t avg_diag;
    pixel_t avg_cross;
    pixel_t avg_h;
    pixel_t avg_v;
    pixel_t r_val;
    pixel_t g_val;
    pixel_t b_val;
    pixel_t g_hold;
    pixel_t b_hold;
    logic   load_r;

    assign cross_sum = cross_h + cross_v;
    assign avg_diag  = pixel_t'(diag_sum >> 2);
    assign avg_cross = pixel_t'(cross_sum >> 2);
    assign avg_h     = pixel_t'(cross_h >> 1);
    assign avg_v     = pixel_t'(cross_v >> 1);

    always_comb begin
        case (kind_q)
            center_r: begin
                r_val = center;
                g_val = avg_cross;
                b_val = avg_diag;
            end
            center_g_rrow: begin
                r_val = avg_h;
                g_val = center;
                b_val = avg_v;
            end
            center_g_brow: begin
                r_val = avg_v;
                g_val = center;
                b_val = avg_h;
            end
            default: begin
                r_val = avg_diag;
                g_val = avg_cross;
                b_val = center;
            end
        endcase
    end

    // output word and tag double as the sequencer state
    assign load_r = sum_valid && (!rgb_valid || color == color_b);
    // a sum can still land while G or B is on the output
    assign accept = !rgb_valid || (color != color_r && !sum_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb_valid <= 1'b0;
            color     <= color_r;
            col_last  <= 1'b0;
            pic_last  <= 1'b0;
        end else if (load_r) begin
            rgb_valid <= 1'b1;
            color     <= color_r;
            col_last  <= col_mark;
            pic_last  <= pic_mark;
        end else if (rgb_valid) begin
            case (color)
                color_r: begin
                    color <= color_g;
                end
                color_g: begin
                    color <= color_b;
                end
                default: begin  // B done, nothing pending
                    rgb_valid <= 1'b0;
                    color     <= color_r;
                    col_last  <= 1'b0;
                    pic_last  <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_r) begin
            rgb_data <= r_val;
            g_hold   <= g_val;
            b_hold   <= b_val;
        end else if (rgb_valid && color == color_r) begin
            rgb_data <= g_hold;
        end else if (rgb_valid && color == color_g) begin
            rgb_data <= b_hold;
        end
    end

endmodule

// ==== logic/neighbor_sums.sv ====
`timescale 1ns/1ns

module neighbor_sums (
    input  logic                       clk,
    input  logic                       rst_n,
    input  demosaic_pkg::pixel_t       p1,
    input  demosaic_pkg::pixel_t       p2,
    input  demosaic_pkg::pixel_t       p3,
    input  demosaic_pkg::pixel_t       p4,
    input  demosaic_pkg::pixel_t       p5,
    input  demosaic_pkg::pixel_t       p6,
    input  demosaic_pkg::pixel_t       p7,
    input  demosaic_pkg::pixel_t       p8,
    input  demosaic_pkg::pixel_t       p9,
    input  demosaic_pkg::center_kind_e kind,
    input  logic                       tap_valid,
    input  logic                       end_col_q,
    input  logic                       end_pic_q,
    input  logic                       accept,
    output demosaic_pkg::sum_t         diag_sum,
    output demosaic_pkg::sum_t         cross_h,
    output demosaic_pkg::sum_t         cross_v,
    output demosaic_pkg::pixel_t       center,
    output demosaic_pkg::center_kind_e kind_q,
    output logic                       col_mark,
    output logic                       pic_mark,
    output logic                       sum_valid
);

    import demosaic_pkg::*;

    logic take;

    assign take = tap_valid && accept;  // window lost if serializer busy

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            diag_sum <= sum_t'(p1) + sum_t'(p3) + sum_t'(p7) + sum_t'(p9);
            cross_h  <= sum_t'(p4) + sum_t'(p6);
            cross_v  <= sum_t'(p2) + sum_t'(p8);
            center   <= p5;
            kind_q   <= kind;
            col_mark <= end_col_q;
            pic_mark <= end_pic_q;
        end
    end

endmodule

// ==== logic/bayer_window.sv ====
`timescale 1ns/1ns
`include "demosaic_consts.svh"

module bayer_window (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid,
    input  demosaic_pkg::pixel_t       data_in,
    input  logic                       end_col,
    input  logic                       end_pic,
    output demosaic_pkg::pixel_t       p1,
    output demosaic_pkg::pixel_t       p2,
    output demosaic_pkg::pixel_t       p3,
    output demosaic_pkg::pixel_t       p4,
    output demosaic_pkg::pixel_t       p5,
    output demosaic_pkg::pixel_t       p6,
    output demosaic_pkg::pixel_t       p7,
    output demosaic_pkg::pixel_t       p8,
    output demosaic_pkg::pixel_t       p9,
    output demosaic_pkg::center_kind_e kind,
    output logic                       tap_valid,
    output logic                       end_col_q,
    output logic                       end_pic_q
);

    import demosaic_pkg::*;

    localparam logic [`DM_ROW_W-1:0] last_row = `DM_ROW_W'(`DM_COL_H - 1);
    localparam logic [`DM_ROW_W-1:0] fill_rows = `DM_ROW_W'(1);

    logic                  valid_q;
    pixel_t                data_q;
    pos_state_e            state;
    logic [`DM_ROW_W-1:0]  counter;
    logic [`DM_ROW_W-1:0]  row_up1;
    logic [`DM_ROW_W-1:0]  row_up2;
    logic                  col_par;   // toggles per column shift
    pixel_t                left_buf [`DM_COL_H];
    pixel_t                mid_buf  [`DM_COL_H];
    pixel_t                new_buf  [`DM_COL_H];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            end_col_q <= 1'b0;
            end_pic_q <= 1'b0;
        end else begin
            valid_q   <= valid;
            end_col_q <= end_col;
            end_pic_q <= end_pic;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= fill_first;
            counter <= '0;
            col_par <= 1'b0;
        end else if (valid_q) begin
            case (state)
                fill_first: begin
                    counter <= counter + 1'b1;
                    if (counter == last_row) begin
                        state <= fill_second;
                    end
                end
                fill_second: begin
                    counter <= counter + 1'b1;
                    if (counter == last_row) begin
                        state <= fill_new;
                    end
                end
                fill_new: begin
                    counter <= counter + 1'b1;
                    if (counter == fill_rows) begin
                        state <= window;
                    end
                end
                default: begin
                    if (end_col_q) begin  // strip done, refill
                        state   <= fill_first;
                        counter <= '0;
                        col_par <= 1'b0;
                    end else if (counter == last_row) begin
                        state   <= fill_new;
                        counter <= '0;
                        col_par <= ~col_par;
                    end else begin
                        counter <= counter + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            case (state)
                fill_first: begin
                    left_buf[counter] <= data_q;
                end
                fill_second: begin
                    mid_buf[counter] <= data_q;
                end
                default: begin
                    new_buf[counter] <= data_q;
                    if (state == window && counter == last_row && !end_col_q) begin
                        for (int i = 0; i < `DM_COL_H; i++) begin
                            left_buf[i] <= mid_buf[i];
                        end
                        for (int i = 0; i < `DM_COL_H - 1; i++) begin
                            mid_buf[i] <= new_buf[i];
                        end
                        mid_buf[last_row] <= data_q;  // bottom sample is still live
                    end
                end
            endcase
        end
    end

    assign row_up1 = counter - 3'd1;
    assign row_up2 = counter - 3'd2;

    assign p1 = left_buf[row_up2];
    assign p2 = mid_buf[row_up2];
    assign p3 = new_buf[row_up2];
    assign p4 = left_buf[row_up1];
    assign p5 = mid_buf[row_up1];
    assign p6 = new_buf[row_up1];
    assign p7 = left_buf[counter];
    assign p8 = mid_buf[counter];
    assign p9 = data_q;

    // middle column is odd when parity is clear
    assign kind      = center_kind_e'({row_up1[0], ~col_par});
    assign tap_valid = valid_q && (state == window);

endmodule

// ==== logic/demosaic_pkg.sv ====
`include "demosaic_consts.svh"

package demosaic_pkg;

    typedef logic [`DM_PIX_W-1:0] pixel_t;
    typedef logic [`DM_SUM_W-1:0] sum_t;

    typedef enum logic [1:0] {
        fill_first  = 2'd0,  // loading left column
        fill_second = 2'd1,  // loading middle column
        fill_new    = 2'd2,  // top two rows of a new column
        window      = 2'd3   // every sample completes a 3x3
    } pos_state_e;

    // encoded as {row odd, column odd} of the centre, RGGB layout
    typedef enum logic [1:0] {
        center_r      = 2'd0,
        center_g_rrow = 2'd1,
        center_g_brow = 2'd2,
        center_b      = 2'd3
    } center_kind_e;

    typedef enum logic [1:0] {
        color_r = 2'd0,
        color_g = 2'd1,
        color_b = 2'd2
    } color_e;

endpackage

// ==== logic/demosaic_consts.svh ====
`ifndef DEMOSAIC_CONSTS_SVH
`define DEMOSAIC_CONSTS_SVH

// raw sample width
`define DM_PIX_W 8

// holds a sum of four samples
`define DM_SUM_W 10

// samples per column of a strip
`define DM_COL_H 8

// row counter width, counts 0 .. DM_COL_H-1
`define DM_ROW_W 3

`endif
